// ==== armDp.f ====
armDpPkg.sv
instrDecode.sv
regFile.sv
alu.sv
retireUnit.sv
armDpCore.sv
armDpTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := armDpTb
RTL_TOP   := armDpCore
FILELIST  := armDp.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -q "Simulation PASSED"; then \
		exit 0; \
	else \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== armDpTb.sv ====
`timescale 1ns/1ps

module armDpTb
  import armDpPkg::*;
;

  localparam int timeoutCycles = 6000;  // About 450 instrs at 3 cycles each with wide margin

  typedef struct packed {
    logic        executed;
    logic        wrote;
    logic [3:0]  rd;
    logic [31:0] result;
    logic [3:0]  flags;   // NZCV after this retire
    logic [31:0] cycle;   // Expected retire cycle
  } retireExp_t;

  logic        clk;
  logic        reset;
  logic        instrValid;
  dpInstr_t    instr;
  logic        retireValid, retireExecuted, retireWrote;
  logic [3:0]  retireRd;
  logic [31:0] retireResult;
  logic [3:0]  flags;

  logic [31:0] cycles;
  logic [31:0] seed;
  logic [31:0] shadowRegs [0:14];  // Reference r0 to r14
  logic [3:0]  shadowFlags;        // Reference NZCV
  retireExp_t  expQ [$];           // Outstanding retires in order

  armDpCore armDpCore_inst (
    .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
    .retireValid(retireValid), .retireExecuted(retireExecuted), .retireWrote(retireWrote),
    .retireRd(retireRd), .retireResult(retireResult), .flags(flags)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped on first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      reportFail($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  function automatic logic [31:0] lcgNext();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic [31:0] rotr(input logic [31:0] x, input logic [5:0] amt);
    return (x >> amt) | (x << (6'd32 - amt));  // amt 0 gives x
  endfunction

  function automatic logic [31:0] regVal(input logic [3:0] a);
    return (a == 4'd15) ? 32'b0 : shadowRegs[a];  // PC reads zero
  endfunction

  // ARM AddWithCarry returning {C, V, result}
  function automatic logic [33:0] addWithCarry(input logic [31:0] x, input logic [31:0] y,
                                               input logic cin);
    logic [32:0] s;
    logic        v;
    s = {1'b0, x} + {1'b0, y} + {32'b0, cin};
    v = (x[31] == y[31]) && (s[31] != x[31]);
    return {s[32], v, s[31:0]};
  endfunction

  function automatic logic condHolds(input logic [3:0] c, input logic [3:0] f);
    logic n, z, cf, v;
    n = f[flagN];
    z = f[flagZ];
    cf = f[flagC];
    v = f[flagV];
    case (c)
      condEq: return z;
      condNe: return !z;
      condCs: return cf;
      condCc: return !cf;
      condMi: return n;
      condPl: return !n;
      condVs: return v;
      condVc: return !v;
      condHi: return cf && !z;
      condLs: return !cf || z;
      condGe: return n == v;
      condLt: return n != v;
      condGt: return !z && (n == v);
      condLe: return z || (n != v);
      condAl: return 1'b1;
      default: return 1'b0;  // Never
    endcase
  endfunction

  function automatic dpInstr_t makeImm(input logic [3:0] c, input logic [3:0] op, input logic s,
                                       input logic [3:0] rn, input logic [3:0] rd,
                                       input logic [3:0] rot, input logic [7:0] imm8);
    dpInstr_t w;
    w.immForm = '{cond: c, instrClass: 2'b00, iBit: 1'b1, opcode: op, sBit: s,
                  rn: rn, rd: rd, rot: rot, imm8: imm8};
    return w;
  endfunction

  function automatic dpInstr_t makeReg(input logic [3:0] c, input logic [3:0] op, input logic s,
                                       input logic [3:0] rn, input logic [3:0] rd,
                                       input logic [3:0] rm);
    dpInstr_t w;
    w.regForm = '{cond: c, instrClass: 2'b00, iBit: 1'b0, opcode: op, sBit: s,
                  rn: rn, rd: rd, shiftField: 8'h00, rm: rm};
    return w;
  endfunction

  // Reference model step for one instruction
  task automatic predict(input dpInstr_t w);
    logic [31:0] a, op2, r;
    logic [33:0] acw;
    logic        logical, c, v, exec, sFlag, isCmp;
    retireExp_t  e;
    op2 = w.immForm.iBit ? rotr({24'b0, w.immForm.imm8}, {1'b0, w.immForm.rot, 1'b0})
                         : regVal(w.regForm.rm);  // Shift field ignored
    a = regVal(w.immForm.rn);
    logical = 1'b1;
    acw = '0;
    case (w.immForm.opcode)
      opAnd, opTst: r = a & op2;
      opEor, opTeq: r = a ^ op2;
      opOrr:        r = a | op2;
      opBic:        r = a & ~op2;
      opMov:        r = op2;
      opMvn:        r = ~op2;
      default: begin
        logical = 1'b0;
        case (w.immForm.opcode)
          opAdd, opCmn: acw = addWithCarry(a, op2, 1'b0);
          opAdc:        acw = addWithCarry(a, op2, shadowFlags[flagC]);
          opSub, opCmp: acw = addWithCarry(a, ~op2, 1'b1);
          opSbc:        acw = addWithCarry(a, ~op2, shadowFlags[flagC]);
          opRsb:        acw = addWithCarry(op2, ~a, 1'b1);
          default:      acw = addWithCarry(op2, ~a, shadowFlags[flagC]);  // RSC
        endcase
        r = acw[31:0];
      end
    endcase
    c = logical ? shadowFlags[flagC] : acw[33];  // Logical keeps C and V
    v = logical ? shadowFlags[flagV] : acw[32];
    isCmp = (w.immForm.opcode[3:2] == 2'b10);
    sFlag = w.immForm.sBit || isCmp;
    exec = (w.immForm.instrClass == 2'b00) && condHolds(w.immForm.cond, shadowFlags);
    e.executed = exec;
    e.wrote = exec && !isCmp && (w.immForm.rd != 4'd15);
    e.rd = w.immForm.rd;
    e.result = r;
    if (e.wrote)
      shadowRegs[w.immForm.rd] = r;
    if (exec && sFlag)
      shadowFlags = {r[31], (r == 32'b0), c, v};
    e.flags = shadowFlags;
    e.cycle = cycles + 32'd2;  // Fixed two-cycle latency
    expQ.push_back(e);
  endtask

  task automatic sendInstr(input dpInstr_t w);
    @(negedge clk);
    instrValid = 1'b1;
    instr = w;
    predict(w);
  endtask

  task automatic finishBurst();
    @(negedge clk);
    instrValid = 1'b0;
    while (expQ.size() > 0)
      @(negedge clk);
  endtask

  // Single instruction, returns with its retire on the outputs
  task automatic run(input dpInstr_t w);
    sendInstr(w);
    @(negedge clk);
    instrValid = 1'b0;
    @(negedge clk);
    while (!retireValid)
      @(negedge clk);
  endtask

  // MOV then three ORRs of rotated bytes
  task automatic loadReg(input logic [3:0] r, input logic [31:0] value);
    run(makeImm(condAl, opMov, 1'b0, 4'd0, r, 4'd0, value[7:0]));
    run(makeImm(condAl, opOrr, 1'b0, r, r, 4'd12, value[15:8]));
    run(makeImm(condAl, opOrr, 1'b0, r, r, 4'd8, value[23:16]));
    run(makeImm(condAl, opOrr, 1'b0, r, r, 4'd4, value[31:24]));
  endtask

  task automatic immTest();
    logic [7:0]  b;
    logic [31:0] rnd;
    for (int rot = 0; rot < 16; rot++) begin
      rnd = lcgNext();
      b = rnd[31:24];
      run(makeImm(condAl, opMov, 1'b0, 4'd0, 4'd1, rot[3:0], b));
      check("retireResult", retireResult, rotr({24'b0, b}, {rot[4:0], 1'b0}));  // Rotated constant
      check("retireWrote", {31'b0, retireWrote}, 32'd1);
      run(makeImm(condAl, opMvn, 1'b0, 4'd0, 4'd2, rot[3:0], b));
    end
    run(makeReg(condAl, opMov, 1'b0, 4'd0, 4'd3, 4'd1));  // Register form
  endtask

  task automatic arithTest();
    logic [3:0]  ops [6];
    logic [31:0] rnd;
    ops = '{opAdd, opSub, opRsb, opAdc, opSbc, opRsc};
    for (int i = 0; i < 30; i++) begin
      loadReg(4'd1 + {3'b0, i[0]}, lcgNext());
      rnd = lcgNext() % 32'd6;
      run(makeReg(condAl, ops[rnd[2:0]], 1'b1, 4'd1, 4'd3, 4'd2));
      rnd = lcgNext() % 32'd6;
      run(makeReg(condAl, ops[rnd[2:0]], 1'b1, 4'd3, 4'd4, 4'd1));  // Chained carry
    end
  endtask

  task automatic logicTest();
    logic [3:0] ops [4];
    ops = '{opAnd, opEor, opOrr, opBic};
    for (int i = 0; i < 8; i++) begin
      loadReg(4'd1, lcgNext());
      run(makeReg(condAl, opSub, 1'b1, 4'd1, 4'd0, 4'd2));   // Sets C and V
      run(makeReg(condAl, ops[i[1:0]], 1'b1, 4'd1, 4'd5, 4'd2));
    end
  endtask

  task automatic compareTest();
    logic [3:0] ops [4];
    ops = '{opTst, opTeq, opCmp, opCmn};
    for (int i = 0; i < 4; i++) begin
      loadReg(4'd2, lcgNext());
      run(makeReg(condAl, ops[i[1:0]], 1'b0, 4'd1, 4'd4, 4'd2));  // S forced
      check("retireWrote", {31'b0, retireWrote}, 32'd0);
      run(makeImm(condAl, opAdd, 1'b0, 4'd4, 4'd6, 4'd0, 8'd0));  // Read back r4
    end
  endtask

  // Known NZCV patterns from r7 = 0 and r8 = 0x80000000
  task automatic setFlagPattern(input int k);
    case (k)
      0: run(makeImm(condAl, opCmp, 1'b1, 4'd7, 4'd0, 4'd0, 8'd0));   // 0110
      1: run(makeImm(condAl, opCmp, 1'b1, 4'd7, 4'd0, 4'd0, 8'd1));   // 1000
      2: run(makeImm(condAl, opCmp, 1'b1, 4'd8, 4'd0, 4'd0, 8'd1));   // 0011
      3: run(makeReg(condAl, opCmn, 1'b1, 4'd8, 4'd0, 4'd8));         // 0111
      default: run(makeReg(condAl, opCmp, 1'b1, 4'd7, 4'd0, 4'd8));   // 1001
    endcase
  endtask

  task automatic condTest();
    logic [3:0] pats [5];
    pats = '{4'b0110, 4'b1000, 4'b0011, 4'b0111, 4'b1001};  // Same order as setFlagPattern
    run(makeImm(condAl, opMov, 1'b0, 4'd0, 4'd7, 4'd0, 8'd0));
    run(makeImm(condAl, opMov, 1'b0, 4'd0, 4'd8, 4'd1, 8'd2));  // 0x80000000
    for (int c = 0; c < 16; c++) begin
      for (int k = 0; k < 5; k++) begin
        setFlagPattern(k);
        run(makeImm(c[3:0], opAdd, 1'b0, 4'd10, 4'd10, 4'd0, 8'd1));
        check("retireExecuted", {31'b0, retireExecuted},
              {31'b0, condHolds(c[3:0], pats[k[2:0]])});
      end
    end
  endtask

  task automatic burstTest();
    dpInstr_t    w;
    logic [31:0] rnd;
    for (int i = 0; i < 6; i++)
      sendInstr(makeImm(condAl, opAdd, 1'b1, 4'd1, 4'd1, 4'd0, 8'd3));  // Bypass chain
    sendInstr(makeImm(condAl, opMov, 1'b0, 4'd0, 4'd15, 4'd0, 8'd5));   // Dropped write
    sendInstr(makeImm(condAl, opAdd, 1'b0, 4'd15, 4'd3, 4'd0, 8'd7));   // r15 reads zero
    w = makeImm(condAl, opMov, 1'b0, 4'd0, 4'd2, 4'd0, 8'd9);
    w.immForm.instrClass = 2'b01;                                     // Not data processing
    sendInstr(w);
    w.immForm.instrClass = 2'b10;
    sendInstr(w);
    for (int i = 0; i < 20; i++) begin
      rnd = lcgNext();
      sendInstr(makeReg(condAl, rnd[31:28], rnd[27], 4'd1 + {2'b0, rnd[25:24]},
                        4'd1 + {2'b0, rnd[23:22]}, 4'd1 + {2'b0, rnd[21:20]}));
    end
    finishBurst();
  endtask

  // Retire checker samples on the falling edge
  always @(negedge clk) begin
    retireExp_t e;
    if (!reset && retireValid) begin
      if (expQ.size() == 0) begin
        reportFail("retire seen with no instruction outstanding");
      end else begin
        e = expQ.pop_front();
        check("retire cycle", cycles, e.cycle);
        check("retireExecuted", {31'b0, retireExecuted}, {31'b0, e.executed});
        check("retireWrote", {31'b0, retireWrote}, {31'b0, e.wrote});
        check("retireRd", {28'b0, retireRd}, {28'b0, e.rd});
        if (e.executed)
          check("retireResult", retireResult, e.result);
        check("flags", {28'b0, flags}, {28'b0, e.flags});
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 32'd1;
    if (cycles >= timeoutCycles)
      reportFail("timeout, the tests did not finish in time");
  end

  initial begin
    reset = 1'b1;
    instrValid = 1'b0;
    instr = '0;
    cycles = 32'd0;
    seed = 32'd62862;
    shadowFlags = 4'b0;
    for (int i = 0; i < 15; i++)
      shadowRegs[i[3:0]] = 32'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check("flags", {28'b0, flags}, 32'd0);
    check("retireValid", {31'b0, retireValid}, 32'd0);
    immTest();
    arithTest();
    logicTest();
    compareTest();
    condTest();
    burstTest();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== armDpCore.sv ====
`timescale 1ns/1ps

module armDpCore
  import armDpPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        instrValid,      // One-cycle strobe
  input  dpInstr_t    instr,
  output logic        retireValid,     // Two cycles after strobe
  output logic        retireExecuted,
  output logic        retireWrote,
  output logic [3:0]  retireRd,
  output logic [31:0] retireResult,
  output logic [3:0]  flags
);

  logic [3:0]  rnAddr, rmAddr;
  logic [31:0] rnData, rmData;
  logic        opValid;
  logic [3:0]  aluControl;
  logic [31:0] opA, opB;
  logic [3:0]  cond;
  logic        setFlags;
  logic [3:0]  rd;
  logic        legal;
  logic [31:0] aluResult;
  logic [3:0]  aluFlags;
  logic        doNotWriteReg;
  logic        wrEnable;
  logic [3:0]  wrAddr;
  logic [31:0] wrData;

  // Decode, operand fetch, stage register
  instrDecode instrDecode_inst (
    .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
    .rnAddr(rnAddr), .rmAddr(rmAddr), .rnData(rnData), .rmData(rmData),
    .opValid(opValid), .aluControl(aluControl), .opA(opA), .opB(opB),
    .cond(cond), .setFlags(setFlags), .rd(rd), .legal(legal)
  );

  // r0 to r14 with bypass
  regFile regFile_inst (
    .clk(clk), .reset(reset), .rnAddr(rnAddr), .rmAddr(rmAddr),
    .wrEnable(wrEnable), .wrAddr(wrAddr), .wrData(wrData),
    .rnData(rnData), .rmData(rmData)
  );

  // Execute on stage fields
  alu alu_inst (
    .a(opA), .b(opB), .ALUControl(aluControl), .previousFlags(flags),
    .Result(aluResult), .Flags(aluFlags), .doNotWriteReg(doNotWriteReg)
  );

  // Condition, write-back, retire
  retireUnit retireUnit_inst (
    .clk(clk), .reset(reset), .opValid(opValid), .cond(cond),
    .setFlags(setFlags), .rd(rd), .legal(legal), .aluResult(aluResult),
    .aluFlags(aluFlags), .doNotWriteReg(doNotWriteReg), .flags(flags),
    .wrEnable(wrEnable), .wrAddr(wrAddr), .wrData(wrData),
    .retireValid(retireValid), .retireExecuted(retireExecuted),
    .retireWrote(retireWrote), .retireRd(retireRd), .retireResult(retireResult)
  );

endmodule

// ==== retireUnit.sv ====
`timescale 1ns/1ps

module retireUnit
  import armDpPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        opValid,
  input  logic [3:0]  cond,
  input  logic        setFlags,
  input  logic [3:0]  rd,
  input  logic        legal,
  input  logic [31:0] aluResult,
  input  logic [3:0]  aluFlags,
  input  logic        doNotWriteReg,
  output logic [3:0]  flags,           // NZCV register
  output logic        wrEnable,
  output logic [3:0]  wrAddr,
  output logic [31:0] wrData,
  output logic        retireValid,
  output logic        retireExecuted,
  output logic        retireWrote,
  output logic [3:0]  retireRd,
  output logic [31:0] retireResult
);

  logic n, z, c, v;
  logic condPass;
  logic execute;   // Valid, legal and condition met

  assign n = flags[flagN];
  assign z = flags[flagZ];
  assign c = flags[flagC];
  assign v = flags[flagV];

  // ARM condition table
  always_comb begin
    case (cond)
      condEq:  condPass = z;
      condNe:  condPass = ~z;
      condCs:  condPass = c;
      condCc:  condPass = ~c;
      condMi:  condPass = n;
      condPl:  condPass = ~n;
      condVs:  condPass = v;
      condVc:  condPass = ~v;
      condHi:  condPass = c & ~z;
      condLs:  condPass = ~c | z;
      condGe:  condPass = (n == v);
      condLt:  condPass = (n != v);
      condGt:  condPass = ~z & (n == v);
      condLe:  condPass = z | (n != v);
      condAl:  condPass = 1'b1;
      default: condPass = 1'b0;  // 1111 never
    endcase
  end

  assign execute = opValid & legal & condPass;

  // Register file write, r15 dropped
  assign wrEnable = execute & ~doNotWriteReg & (rd != 4'd15);
  assign wrAddr   = rd;
  assign wrData   = aluResult;

  // Flags and retire strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      flags          <= 4'b0;
      retireValid    <= 1'b0;
      retireExecuted <= 1'b0;
      retireWrote    <= 1'b0;
    end else begin
      if (execute && setFlags)
        flags <= aluFlags;       // Visible to next cond test
      retireValid    <= opValid;
      retireExecuted <= execute;
      retireWrote    <= wrEnable;
    end
  end

  // Retire payload
  always_ff @(posedge clk) begin
    retireRd     <= rd;
    retireResult <= aluResult;
  end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu
  import armDpPkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [3:0]  ALUControl,
  input  logic [3:0]  previousFlags,  // Current NZCV
  output logic [31:0] Result,
  output logic [3:0]  Flags,
  output logic        doNotWriteReg
);

  logic        neg, zero, carry, overflow;
  logic        invertB;
  logic        aluCarry;
  logic        isArith;
  logic [31:0] condinvb;
  logic [32:0] sum;

  // Subtract-type ops and MVN take ~b
  always_comb begin
    case (ALUControl)
      opSub, opRsb, opSbc, opRsc, opCmp, opMvn: invertB = 1'b1;
      default:                                  invertB = 1'b0;
    endcase
  end

  // Adder carry-in
  always_comb begin
    case (ALUControl)
      opSub, opRsb, opCmp: aluCarry = 1'b1;                  // Two's complement
      opAdc, opSbc, opRsc: aluCarry = previousFlags[flagC];  // Chained carry
      default:             aluCarry = 1'b0;
    endcase
  end

  // One shared adder
  assign condinvb = invertB ? ~b : b;
  assign sum      = {1'b0, a} + {1'b0, condinvb} + {32'b0, aluCarry};

  // Result select
  always_comb begin
    case (ALUControl)
      opAnd, opTst: Result = a & b;
      opEor, opTeq: Result = a ^ b;
      opOrr:        Result = a | b;
      opBic:        Result = a & ~b;
      default:      Result = sum[31:0];  // Add-type, MOV, MVN
    endcase
  end

  // Ops whose C and V come from the adder
  always_comb begin
    case (ALUControl)
      opSub, opRsb, opAdd, opAdc, opSbc, opRsc, opCmp, opCmn: isArith = 1'b1;
      default:                                                 isArith = 1'b0;
    endcase
  end

  // Compare and test never write Rd
  assign doNotWriteReg = (ALUControl[3:2] == 2'b10);

  assign neg  = Result[31];
  assign zero = (Result == 32'b0);

  // Logical ops keep C and V
  assign carry    = isArith ? sum[32] : previousFlags[flagC];
  assign overflow = isArith ? ((a[31] == condinvb[31]) && (sum[31] != a[31]))  // Signed overflow
                            : previousFlags[flagV];

  // Order is NZCV
  assign Flags = {neg, zero, carry, overflow};

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        reset,
  input  logic [3:0]  rnAddr,
  input  logic [3:0]  rmAddr,
  input  logic        wrEnable,
  input  logic [3:0]  wrAddr,
  input  logic [31:0] wrData,
  output logic [31:0] rnData,
  output logic [31:0] rmData
);

  logic [31:0] regs [0:14];  // r0 to r14, no r15 storage

  // Write port, r15 writes dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 15; i++)
        regs[i] <= 32'b0;
    end else if (wrEnable && (wrAddr != 4'd15)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Read port A with write-through
  always_comb begin
    if (rnAddr == 4'd15)
      rnData = 32'b0;                  // PC not modeled
    else if (wrEnable && (wrAddr == rnAddr))
      rnData = wrData;                 // Bypass same-cycle write
    else
      rnData = regs[rnAddr];
  end

  // Read port B, same rules
  always_comb begin
    if (rmAddr == 4'd15)
      rmData = 32'b0;
    else if (wrEnable && (wrAddr == rmAddr))
      rmData = wrData;
    else
      rmData = regs[rmAddr];
  end

endmodule

// ==== instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode
  import armDpPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        instrValid,
  input  dpInstr_t    instr,
  output logic [3:0]  rnAddr,     // Register file read port A
  output logic [3:0]  rmAddr,     // Register file read port B
  input  logic [31:0] rnData,
  input  logic [31:0] rmData,
  output logic        opValid,    // Stage holds an instruction
  output logic [3:0]  aluControl,
  output logic [31:0] opA,
  output logic [31:0] opB,
  output logic [3:0]  cond,
  output logic        setFlags,
  output logic [3:0]  rd,
  output logic        legal
);

  logic [31:0] immZx;    // Zero-extended imm8
  logic [63:0] immPair;  // Doubled word for rotate
  logic [4:0]  rotAmt;   // Twice rot
  logic [31:0] immRot;   // Expanded constant
  logic [31:0] op2;      // Second source operand
  logic [31:0] nextA;
  logic [31:0] nextB;
  logic        isCompare;
  logic        nextSetFlags;
  logic        nextLegal;

  // Read addresses go straight from the incoming word
  assign rnAddr = instr.immForm.rn;
  assign rmAddr = instr.regForm.rm;

  // Rotate right by 2*rot via doubled word
  assign immZx   = {24'b0, instr.immForm.imm8};
  assign rotAmt  = {instr.immForm.rot, 1'b0};
  assign immPair = {immZx, immZx} >> rotAmt;
  assign immRot  = immPair[31:0];

  // Pick union view by I bit
  always_comb begin
    if (instr.immForm.iBit)
      op2 = immRot;          // Immediate form
    else
      op2 = rmData;          // Register form, shift ignored
  end

  // Operand steering per opcode
  always_comb begin
    case (instr.immForm.opcode)
      opRsb, opRsc: begin    // Reverse subtract, swap sources
        nextA = op2;
        nextB = rnData;
      end
      opMov, opMvn: begin    // Single operand, zero first source
        nextA = 32'b0;
        nextB = op2;
      end
      default: begin
        nextA = rnData;
        nextB = op2;
      end
    endcase
  end

  assign isCompare    = (instr.immForm.opcode[3:2] == 2'b10);  // TST TEQ CMP CMN
  assign nextSetFlags = instr.immForm.sBit | isCompare;
  assign nextLegal    = (instr.immForm.instrClass == 2'b00);   // Data processing only

  // Stage valid
  always_ff @(posedge clk) begin
    if (reset)
      opValid <= 1'b0;
    else
      opValid <= instrValid;
  end

  // Stage payload, loaded on strobe
  always_ff @(posedge clk) begin
    if (instrValid) begin
      aluControl <= instr.immForm.opcode;
      opA        <= nextA;
      opB        <= nextB;
      cond       <= instr.immForm.cond;
      setFlags   <= nextSetFlags;
      rd         <= instr.immForm.rd;
      legal      <= nextLegal;
    end
  end

endmodule

// ==== armDpPkg.sv ====
package armDpPkg;

  // Immediate form, bit 25 set
  typedef struct packed {
    logic [3:0] cond;       // Condition field
    logic [1:0] instrClass; // Bits 27:26, zero for data processing
    logic       iBit;       // Immediate select
    logic [3:0] opcode;     // Data-processing opcode
    logic       sBit;       // Set flags
    logic [3:0] rn;         // First operand register
    logic [3:0] rd;         // Destination register
    logic [3:0] rot;        // Rotate right by twice this
    logic [7:0] imm8;       // 8-bit constant
  } dpImmForm_t;

  // Register form, bit 25 clear
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] instrClass;
    logic       iBit;
    logic [3:0] opcode;
    logic       sBit;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [7:0] shiftField; // Shift spec, not implemented
    logic [3:0] rm;         // Second operand register
  } dpRegForm_t;

  // Same 32-bit word, two decodings picked by iBit
  typedef union packed {
    dpImmForm_t immForm;
    dpRegForm_t regForm;
  } dpInstr_t;

  // Data-processing opcodes
  localparam logic [3:0] opAnd = 4'b0000, opEor = 4'b0001, opSub = 4'b0010, opRsb = 4'b0011;
  localparam logic [3:0] opAdd = 4'b0100, opAdc = 4'b0101, opSbc = 4'b0110, opRsc = 4'b0111;
  localparam logic [3:0] opTst = 4'b1000, opTeq = 4'b1001, opCmp = 4'b1010, opCmn = 4'b1011;
  localparam logic [3:0] opOrr = 4'b1100, opMov = 4'b1101, opBic = 4'b1110, opMvn = 4'b1111;

  // Condition codes, 1111 is never
  localparam logic [3:0] condEq = 4'b0000, condNe = 4'b0001, condCs = 4'b0010;
  localparam logic [3:0] condCc = 4'b0011, condMi = 4'b0100, condPl = 4'b0101;
  localparam logic [3:0] condVs = 4'b0110, condVc = 4'b0111, condHi = 4'b1000;
  localparam logic [3:0] condLs = 4'b1001, condGe = 4'b1010, condLt = 4'b1011;
  localparam logic [3:0] condGt = 4'b1100, condLe = 4'b1101, condAl = 4'b1110;

  // Flag bit positions, order is NZCV
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

endpackage
